// File: flist.f
+incdir+verilog
verilog/tlp_pkg.sv
verilog/slv_pkg.sv
verilog/tlp_rx_parser.sv
verilog/rx_credit_release.sv
verilog/slv_sequencer.sv
verilog/cpl_transmitter.sv
verilog/pcie_tlp_top.sv
bench/tb_clk_gen.sv
bench/pcie_tlp_properties.sv
bench/tb_pcie_tlp.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_pcie_tlp
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_pcie_tlp.sv
`default_nettype none
`include "tlp_consts.svh"

module tb_pcie_tlp;
	timeunit 1ns;
	timeprecision 100ps;
	import tlp_pkg::*;
	import slv_pkg::*;

	localparam int N_TLP = 22;
	localparam int WORST_CYC = 80;
	localparam int WATCHDOG_NS = (N_TLP * WORST_CYC + 200) * 8;

	typedef struct packed {
		logic [`SLV_ADR_W-1:0]  adr;
		logic [`TLP_DATA_W-1:0] dat;
		logic [1:0]             sel;
	} wr_exp_t;

	logic pcie_clk;
	logic sys_rst;
	logic [`BAR_W-1:0] rx_bar_hit_i;
	cfg_id_t cfg_id_i;
	logic rx_st_i;
	logic rx_end_i;
	logic [`TLP_DATA_W-1:0] rx_data_i;
	logic tx_req_o;
	logic tx_rdy_i;
	logic tx_st_o;
	logic tx_end_o;
	logic [`TLP_DATA_W-1:0] tx_data_o;
	logic [7:0] pd_num_o;
	logic ph_cr_o;
	logic pd_cr_o;
	logic nph_cr_o;
	logic npd_cr_o;
	slv_req_t slv_o;
	logic [`TLP_DATA_W-1:0] slv_dat_i;

	logic [31:0] seed;
	int checks;
	int errors;
	logic [15:0] cur_req_id;
	logic [7:0] cur_tag;
	logic [`BAR_W-1:0] cur_bar;
	logic in_pkt;
	logic [15:0] pay_q[$];
	wr_exp_t exp_wr[$];
	logic [15:0] exp_tx[$];
	logic [15:0] mem [int];        // Slave model
	logic [15:0] exp_mem [int];    // Reference contents

	tb_clk_gen tb_clk_gen_i (
		.pcie_clk_o (pcie_clk),
		.sys_rst_o  (sys_rst)
	);

	pcie_tlp_top pcie_tlp_top_i (
		.pcie_clk     (pcie_clk),
		.sys_rst      (sys_rst),
		.rx_bar_hit_i (rx_bar_hit_i),
		.cfg_id_i     (cfg_id_i),
		.rx_st_i      (rx_st_i),
		.rx_end_i     (rx_end_i),
		.rx_data_i    (rx_data_i),
		.tx_req_o     (tx_req_o),
		.tx_rdy_i     (tx_rdy_i),
		.tx_st_o      (tx_st_o),
		.tx_end_o     (tx_end_o),
		.tx_data_o    (tx_data_o),
		.pd_num_o     (pd_num_o),
		.ph_cr_o      (ph_cr_o),
		.pd_cr_o      (pd_cr_o),
		.nph_cr_o     (nph_cr_o),
		.npd_cr_o     (npd_cr_o),
		.slv_o        (slv_o),
		.slv_dat_i    (slv_dat_i)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function logic [31:0] rnd();
		seed = xorshift32(seed);
		return seed;
	endfunction

	// Untouched memory, every address bit matters
	function automatic logic [15:0] fill_word(input int a);
		return a[15:0] ^ {a[18:16], 13'h0} ^ 16'h5a3c;
	endfunction

	function automatic logic [15:0] mem_word(input int a);
		return mem.exists(a) ? mem[a] : fill_word(a);
	endfunction

	function automatic logic [15:0] exp_word(input int a);
		return exp_mem.exists(a) ? exp_mem[a] : fill_word(a);
	endfunction

	function automatic int low_bit(input logic [3:0] m);
		int r;
		r = 0;
		for (int i = 3; i >= 0; i--)
			if (m[i])
				r = i;
		return r;
	endfunction

	function automatic int high_bit(input logic [3:0] m);
		int r;
		r = 0;
		for (int i = 0; i < 4; i++)
			if (m[i])
				r = i;
		return r;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR %0t: %s expected %0h, got %0h", $time, name, exp, got);
		end
	endtask

	task automatic fail_plain(input string msg);
		errors++;
		$display("%0t: %s", $time, msg);
	endtask

	//----------------------------------------------------------------------
	// Slave memory and monitors
	//----------------------------------------------------------------------
	always @(posedge pcie_clk) begin
		int a;
		logic [15:0] w;
		a = int'(slv_o.adr);
		if (!sys_rst && slv_o.ce && !slv_o.we)
			slv_dat_i <= mem_word(a);
		if (!sys_rst && slv_o.ce && slv_o.we) begin
			w = mem_word(a);
			if (slv_o.sel[1])
				w[15:8] = slv_o.dat[15:8];   // Lower byte address
			if (slv_o.sel[0])
				w[7:0] = slv_o.dat[7:0];
			mem[a] = w;
		end
	end

	always @(negedge pcie_clk) begin
		wr_exp_t e;
		if (!sys_rst && slv_o.ce)
			check_val("slv_o.bar", cur_bar, slv_o.bar);
		if (!sys_rst && slv_o.ce && slv_o.we) begin
			assert (exp_wr.size() != 0) else fail_plain("Slave write with no write pending");
			if (exp_wr.size() != 0) begin
				e = exp_wr.pop_front();
				check_val("slv_o.adr", e.adr, slv_o.adr);
				check_val("slv_o.dat", e.dat, slv_o.dat);
				check_val("slv_o.sel", e.sel, slv_o.sel);
			end
		end
	end

	always @(negedge pcie_clk) begin
		logic [15:0] w;
		if (!sys_rst && (tx_st_o || in_pkt)) begin
			assert (exp_tx.size() != 0) else fail_plain("Transmit word with no completion pending");
			if (exp_tx.size() != 0) begin
				w = exp_tx.pop_front();
				check_val("tx_st_o", !in_pkt, tx_st_o);
				check_val("tx_data_o", w, tx_data_o);
				check_val("tx_end_o", exp_tx.size() == 0, tx_end_o);
				in_pkt = (exp_tx.size() != 0);
			end
		end
	end

	//----------------------------------------------------------------------
	// Stimulus
	//----------------------------------------------------------------------
	task automatic fill_payload(input int len);
		pay_q.delete();
		for (int k = 0; k < 2 * len; k++)
			pay_q.push_back(16'(rnd()));
	endtask

	task automatic send_tlp(input logic [1:0] fmt, input logic [4:0] typ, input int len,
		input logic [3:0] fbe, input logic [3:0] lbe, input logic [63:0] addr,
		input logic [6:0] bar);
		logic [15:0] words[$];
		logic ph;
		logic pd;
		logic nph;
		logic npd;
		int num;
		words.push_back({1'b0, fmt, typ, 8'h00});
		words.push_back({6'h00, 10'(len)});
		words.push_back(cur_req_id);
		words.push_back({cur_tag, lbe, fbe});
		if (fmt[0]) begin
			words.push_back(addr[63:48]);
			words.push_back(addr[47:32]);
		end
		words.push_back(addr[31:16]);
		words.push_back({addr[15:2], 2'b00});
		if (fmt[1])
			foreach (pay_q[j])
				words.push_back(pay_q[j]);
		for (int i = 0; i < words.size(); i++) begin
			rx_data_i <= words[i];
			rx_st_i <= (i == 0);
			rx_end_i <= (i == words.size() - 1);
			rx_bar_hit_i <= bar;
			@(posedge pcie_clk);
		end
		rx_st_i <= 1'b0;
		rx_end_i <= 1'b0;
		ph = 0;
		pd = 0;
		nph = 0;
		npd = 0;
		num = 0;
		if (typ[4]) begin                  // Message
			ph = 1;
			if (fmt[1]) begin
				pd = 1;
				num = (len + 3) / 4;
			end
		end else if (typ == `TYPE_CPL) begin
			ph = 0;
		end else if (typ == 5'b00000) begin
			if (bar != 0) begin
				if (fmt[1]) begin
					ph = 1;
					pd = 1;
					num = (len + 3) / 4;
				end else
					nph = 1;
			end
		end else begin                     // IO and config
			nph = 1;
			npd = fmt[1];
		end
		@(negedge pcie_clk);
		check_val("ph_cr_o", ph, ph_cr_o);
		check_val("pd_cr_o", pd, pd_cr_o);
		check_val("nph_cr_o", nph, nph_cr_o);
		check_val("npd_cr_o", npd, npd_cr_o);
		check_val("pd_num_o", num, pd_num_o);
		@(posedge pcie_clk);
	endtask

	task automatic pick_be(input int len, output logic [3:0] fbe, output logic [3:0] lbe);
		if (len == 1) begin
			fbe = 4'(rnd());
			lbe = 4'h0;
		end else begin
			fbe = 4'(rnd() % 15 + 1);
			lbe = 4'(rnd() % 15 + 1);
		end
	endtask

	task automatic grant_link;
		int n;
		n = int'(rnd() % 8);
		@(negedge pcie_clk);
		while (!tx_req_o)
			@(negedge pcie_clk);
		repeat (n) @(posedge pcie_clk);
		@(posedge pcie_clk);
		tx_rdy_i <= 1'b1;
		@(posedge pcie_clk);
		tx_rdy_i <= 1'b0;
	endtask

	task automatic do_write(input logic [63:0] addr, input int len, input logic four_dw);
		logic [3:0] fbe;
		logic [3:0] lbe;
		logic [3:0] be;
		logic [1:0] sel;
		logic [6:0] bar;
		logic [`SLV_ADR_W-1:0] a;
		logic [15:0] w;
		pick_be(len, fbe, lbe);
		bar = 7'(rnd() % 127 + 1);
		cur_bar = bar;
		cur_req_id = 16'(rnd());
		cur_tag = 8'(rnd());
		fill_payload(len);
		for (int k = 0; k < 2 * len; k++) begin
			if (len == 1 || k / 2 == 0)
				be = fbe;
			else if (k / 2 == len - 1)
				be = lbe;
			else
				be = 4'hf;
			sel = k[0] ? {be[2], be[3]} : {be[0], be[1]};
			a = {addr[19:2], 1'b0} + `SLV_ADR_W'(k);
			exp_wr.push_back(wr_exp_t'{a, pay_q[k], sel});
			w = exp_word(int'(a));
			if (sel[1])
				w[15:8] = pay_q[k][15:8];
			if (sel[0])
				w[7:0] = pay_q[k][7:0];
			exp_mem[int'(a)] = w;
		end
		send_tlp({1'b1, four_dw}, 5'b00000, len, fbe, lbe, addr, bar);
		while (exp_wr.size() != 0)
			@(negedge pcie_clk);
		@(posedge pcie_clk);
		@(negedge pcie_clk);
		for (int k = 0; k < 2 * len; k++) begin
			a = {addr[19:2], 1'b0} + `SLV_ADR_W'(k);
			check_val($sformatf("mem[%05h]", a), exp_word(int'(a)), mem_word(int'(a)));
		end
		@(posedge pcie_clk);
	endtask

	task automatic do_read(input logic [63:0] addr, input int len, input logic four_dw);
		logic [3:0] fbe;
		logic [3:0] lbe;
		logic [6:0] bar;
		logic [`SLV_ADR_W-1:0] a;
		int lo;
		int bc;
		pick_be(len, fbe, lbe);
		bar = 7'(rnd() % 127 + 1);
		cur_bar = bar;
		cur_req_id = 16'(rnd());
		cur_tag = 8'(rnd());
		lo = low_bit(fbe);
		if (len == 1)
			bc = (fbe == 4'h0) ? 1 : high_bit(fbe) - lo + 1;
		else
			bc = 4 * len - lo - (3 - high_bit(lbe));
		exp_tx.push_back({1'b0, `FMT_3DW_DATA, `TYPE_CPL, 8'h00});
		exp_tx.push_back({6'h00, 10'(len)});
		exp_tx.push_back(cfg_id_i);
		exp_tx.push_back({4'h0, 12'(bc)});
		exp_tx.push_back(cur_req_id);
		exp_tx.push_back({cur_tag, 1'b0, addr[6:2], 2'(lo)});
		for (int k = 0; k < 2 * len; k++) begin
			a = {addr[19:2], 1'b0} + `SLV_ADR_W'(k);
			exp_tx.push_back(exp_word(int'(a)));
		end
		send_tlp({1'b0, four_dw}, 5'b00000, len, fbe, lbe, addr, bar);
		grant_link();
		while (exp_tx.size() != 0)
			@(negedge pcie_clk);
		repeat (2) @(posedge pcie_clk);
	endtask

	initial begin
		#(WATCHDOG_NS * 1ns);
		$display("Watchdog expired, the run did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		logic [63:0] addr;
		logic four_dw;
		int len;
		seed = 32'haccd;
		checks = 0;
		errors = 0;
		in_pkt = 1'b0;
		rx_bar_hit_i = '0;
		cfg_id_i = 16'h1a28;
		rx_st_i = 1'b0;
		rx_end_i = 1'b0;
		rx_data_i = '0;
		tx_rdy_i = 1'b0;
		slv_dat_i = '0;
		cur_req_id = 16'h0100;
		cur_tag = 8'h00;
		cur_bar = '0;
		@(posedge pcie_clk);
		while (sys_rst)
			@(posedge pcie_clk);
		repeat (2) @(posedge pcie_clk);

		// Credit rules for every TLP class
		send_tlp(2'b00, 5'b00000, 1, 4'hf, 4'h0, 64'h0000_1000, 7'h00);
		fill_payload(2);
		send_tlp(2'b10, 5'b00000, 2, 4'hf, 4'hf, 64'h0000_2000, 7'h00);
		fill_payload(1);
		send_tlp(2'b10, 5'b00010, 1, 4'hf, 4'h0, 64'h0000_0010, 7'h00);
		send_tlp(2'b00, 5'b00010, 1, 4'hf, 4'h0, 64'h0000_0010, 7'h00);
		send_tlp(2'b00, 5'b00100, 1, 4'hf, 4'h0, 64'h0000_0004, 7'h00);
		fill_payload(1);
		send_tlp(2'b10, 5'b00101, 1, 4'hf, 4'h0, 64'h0000_0004, 7'h00);
		send_tlp(2'b01, 5'b10000, 1, 4'h0, 4'h0, 64'h0, 7'h00);
		len = int'(rnd() % 8) + 1;
		fill_payload(len);
		send_tlp(2'b11, 5'b10000, len, 4'hf, 4'hf, 64'h0, 7'h00);
		fill_payload(1);
		send_tlp(2'b10, `TYPE_CPL, 1, 4'h0, 4'h0, 64'h0, 7'h01);

		// Writes, then reads back from the same region
		for (int i = 0; i < 6; i++) begin
			four_dw = i[0];
			len = int'(rnd() % 8) + 1;
			addr = {(four_dw ? rnd() : 32'h0), rnd()};
			addr[1:0] = 2'b00;
			do_write(addr, len, four_dw);
			do_read(addr, len, four_dw);
		end
		addr = {32'h0, rnd()};
		do_read(addr, 4, 1'b0);

		repeat (4) @(posedge pcie_clk);
		errors += pcie_tlp_top_i.pcie_tlp_properties_i.fail_cnt;   // Protocol assertions
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/pcie_tlp_properties.sv
`default_nettype none
`include "tlp_consts.svh"

module pcie_tlp_properties (
	input wire                    pcie_clk,
	input wire                    sys_rst,
	input wire                    tx_req_i,
	input wire                    tx_rdy_i,
	input wire                    tx_st_i,
	input wire                    tx_end_i,
	input wire                    ph_cr_i,
	input wire                    pd_cr_i,
	input wire                    nph_cr_i,
	input wire                    npd_cr_i,
	input wire slv_pkg::slv_req_t slv_i,
	input wire                    cpl_started_i,
	input wire tlp_pkg::cpl_hdr_t cpl_hdr_i
);
	timeunit 1ns;
	timeprecision 100ps;

	logic active;
	logic [`TLP_LEN_W+1:0] pos;        // Cycles since tx_st
	logic [`TLP_LEN_W+1:0] last_pos;
	int fail_cnt;                      // Failed assertions so far

	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			active <= 1'b0;
			pos <= '0;
			last_pos <= '0;
		end else begin
			if (cpl_started_i)
				last_pos <= {1'b0, cpl_hdr_i.length, 1'b0} + 12'd5;   // Six header words first
			if (tx_st_i) begin
				active <= 1'b1;
				pos <= 12'd1;
			end else if (active) begin
				pos <= pos + 12'd1;
				if (tx_end_i)
					active <= 1'b0;
			end
		end
	end

	//----------------------------------------------------------------------
	// Reset values and link request
	//----------------------------------------------------------------------
	reset_quiet: assert property (@(posedge pcie_clk) sys_rst |=> !tx_req_i && !tx_st_i
		&& !tx_end_i && !ph_cr_i && !pd_cr_i && !nph_cr_i && !npd_cr_i && !slv_i.ce)
		else begin
			fail_cnt++;
			$error("Outputs not idle after reset");
		end

	req_held: assert property (@(posedge pcie_clk) disable iff (sys_rst)
		tx_req_i && !tx_rdy_i |=> tx_req_i)
		else begin
			fail_cnt++;
			$error("tx_req_o dropped before tx_rdy_i");
		end

	st_follows: assert property (@(posedge pcie_clk) disable iff (sys_rst)
		tx_req_i && tx_rdy_i |=> tx_st_i && !tx_req_i)
		else begin
			fail_cnt++;
			$error("tx_st_o did not follow the grant");
		end

	st_only_granted: assert property (@(posedge pcie_clk) disable iff (sys_rst)
		tx_st_i |-> $past(tx_req_i && tx_rdy_i))
		else begin
			fail_cnt++;
			$error("tx_st_o without a grant");
		end

	//----------------------------------------------------------------------
	// Completion length, no gaps
	//----------------------------------------------------------------------
	end_on_time: assert property (@(posedge pcie_clk) disable iff (sys_rst)
		active && pos == last_pos |-> tx_end_i)
		else begin
			fail_cnt++;
			$error("Completion did not end after its last data word");
		end

	end_only_last: assert property (@(posedge pcie_clk) disable iff (sys_rst)
		tx_end_i |-> active && pos == last_pos)
		else begin
			fail_cnt++;
			$error("tx_end_o at the wrong word");
		end

endmodule

bind pcie_tlp_top pcie_tlp_properties pcie_tlp_properties_i (
	.pcie_clk      (pcie_clk),
	.sys_rst       (sys_rst),
	.tx_req_i      (tx_req_o),
	.tx_rdy_i      (tx_rdy_i),
	.tx_st_i       (tx_st_o),
	.tx_end_i      (tx_end_o),
	.ph_cr_i       (ph_cr_o),
	.pd_cr_i       (pd_cr_o),
	.nph_cr_i      (nph_cr_o),
	.npd_cr_i      (npd_cr_o),
	.slv_i         (slv_o),
	.cpl_started_i (cpl_started),
	.cpl_hdr_i     (cpl_hdr)
);

`default_nettype wire

// File: bench/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
	output logic pcie_clk_o,
	output logic sys_rst_o
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		pcie_clk_o = 1'b0;
		forever #4 pcie_clk_o = ~pcie_clk_o;   // 8 ns period
	end

	initial begin
		sys_rst_o = 1'b1;
		repeat (8) @(posedge pcie_clk_o);
		sys_rst_o <= 1'b0;
	end

endmodule

`default_nettype wire

// File: verilog/pcie_tlp_top.sv
`default_nettype none
`include "tlp_consts.svh"

module pcie_tlp_top (
	input  wire                    pcie_clk,
	input  wire                    sys_rst,
	input  wire [`BAR_W-1:0]       rx_bar_hit_i,
	input  wire tlp_pkg::cfg_id_t  cfg_id_i,
	input  wire                    rx_st_i,
	input  wire                    rx_end_i,
	input  wire [`TLP_DATA_W-1:0]  rx_data_i,
	output logic                   tx_req_o,
	input  wire                    tx_rdy_i,
	output logic                   tx_st_o,
	output logic                   tx_end_o,
	output logic [`TLP_DATA_W-1:0] tx_data_o,
	output logic [7:0]             pd_num_o,
	output logic                   ph_cr_o,
	output logic                   pd_cr_o,
	output logic                   nph_cr_o,
	output logic                   npd_cr_o,
	output slv_pkg::slv_req_t      slv_o,
	input  wire [`TLP_DATA_W-1:0]  slv_dat_i
);

	tlp_pkg::tlp_hdr_t hdr;
	tlp_pkg::rx_word_t pay;
	tlp_pkg::cpl_hdr_t cpl_hdr;
	logic hdr_valid;
	logic tlp_end;
	logic cpl_valid;
	logic cpl_started;
	logic [`TLP_DATA_W-1:0] cpl_word;
	logic cpl_word_valid;
	logic cpl_credit;

	tlp_rx_parser tlp_rx_parser_i (
		.pcie_clk     (pcie_clk),
		.sys_rst      (sys_rst),
		.rx_bar_hit_i (rx_bar_hit_i),
		.rx_st_i      (rx_st_i),
		.rx_end_i     (rx_end_i),
		.rx_data_i    (rx_data_i),
		.hdr_o        (hdr),
		.hdr_valid_o  (hdr_valid),
		.tlp_end_o    (tlp_end),
		.pay_o        (pay)
	);

	rx_credit_release rx_credit_release_i (
		.pcie_clk  (pcie_clk),
		.sys_rst   (sys_rst),
		.hdr_i     (hdr),
		.tlp_end_i (tlp_end),
		.pd_num_o  (pd_num_o),
		.ph_cr_o   (ph_cr_o),
		.pd_cr_o   (pd_cr_o),
		.nph_cr_o  (nph_cr_o),
		.npd_cr_o  (npd_cr_o)
	);

	slv_sequencer slv_sequencer_i (
		.pcie_clk         (pcie_clk),
		.sys_rst          (sys_rst),
		.hdr_i            (hdr),
		.hdr_valid_i      (hdr_valid),
		.pay_i            (pay),
		.slv_o            (slv_o),
		.slv_dat_i        (slv_dat_i),
		.cpl_hdr_o        (cpl_hdr),
		.cpl_valid_o      (cpl_valid),
		.cpl_started_i    (cpl_started),
		.cpl_word_o       (cpl_word),
		.cpl_word_valid_o (cpl_word_valid),
		.cpl_credit_i     (cpl_credit)
	);

	cpl_transmitter cpl_transmitter_i (
		.pcie_clk         (pcie_clk),
		.sys_rst          (sys_rst),
		.cfg_id_i         (cfg_id_i),
		.cpl_hdr_i        (cpl_hdr),
		.cpl_valid_i      (cpl_valid),
		.cpl_started_o    (cpl_started),
		.cpl_word_i       (cpl_word),
		.cpl_word_valid_i (cpl_word_valid),
		.cpl_credit_o     (cpl_credit),
		.tx_req_o         (tx_req_o),
		.tx_rdy_i         (tx_rdy_i),
		.tx_st_o          (tx_st_o),
		.tx_end_o         (tx_end_o),
		.tx_data_o        (tx_data_o)
	);

endmodule

`default_nettype wire

// File: verilog/cpl_transmitter.sv
`default_nettype none
`include "tlp_consts.svh"

module cpl_transmitter (
	input  wire                    pcie_clk,
	input  wire                    sys_rst,
	input  wire tlp_pkg::cfg_id_t  cfg_id_i,
	input  wire tlp_pkg::cpl_hdr_t cpl_hdr_i,
	input  wire                    cpl_valid_i,
	output logic                   cpl_started_o,
	input  wire [`TLP_DATA_W-1:0]  cpl_word_i,
	input  wire                    cpl_word_valid_i,
	output logic                   cpl_credit_o,
	output logic                   tx_req_o,
	input  wire                    tx_rdy_i,
	output logic                   tx_st_o,
	output logic                   tx_end_o,
	output logic [`TLP_DATA_W-1:0] tx_data_o
);
	import tlp_pkg::*;

	tx_state_e state;
	cpl_hdr_t hdr_q;
	logic [2:0] hcnt;
	logic [`TLP_LEN_W:0] dcnt;
	logic [`TLP_DATA_W-1:0] hdr_word;
	logic [`TLP_DATA_W-1:0] buf_mem [`CPL_BUF_DEPTH];
	logic [$clog2(`CPL_BUF_DEPTH)-1:0] wr_ptr;
	logic [$clog2(`CPL_BUF_DEPTH)-1:0] rd_ptr;
	logic [$clog2(`CPL_BUF_DEPTH):0] fill;
	logic pop;

	assign pop = (state == TX_DATA) && (fill != '0);
	assign cpl_credit_o = pop;   // One credit per word sent

	always_comb begin
		case (hcnt)
			3'd0: hdr_word = {1'b0, `FMT_3DW_DATA, `TYPE_CPL, 1'b0, 3'b000, 4'b0000};
			3'd1: hdr_word = {4'b0000, 2'b00, hdr_q.length};
			3'd2: hdr_word = cfg_id_i;              // Completer ID
			3'd3: hdr_word = {3'b000, 1'b0, hdr_q.bcount};
			3'd4: hdr_word = hdr_q.req_id;
			default: hdr_word = {hdr_q.tag, 1'b0, hdr_q.low_addr};
		endcase
	end

	//----------------------------------------------------------------------
	// Word buffer
	//----------------------------------------------------------------------
	always_ff @(posedge pcie_clk) begin
		if (cpl_word_valid_i)
			buf_mem[wr_ptr] <= cpl_word_i;
	end

	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end else begin
			wr_ptr <= wr_ptr + cpl_word_valid_i;
			rd_ptr <= rd_ptr + pop;
			fill <= fill + cpl_word_valid_i - pop;
		end
	end

	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			state <= TX_IDLE;
			tx_req_o <= 1'b0;
			tx_st_o <= 1'b0;
			tx_end_o <= 1'b0;
			cpl_started_o <= 1'b0;
		end else begin
			tx_st_o <= 1'b0;
			tx_end_o <= 1'b0;
			cpl_started_o <= 1'b0;
			case (state)
				TX_IDLE: begin
					hcnt <= 3'd0;
					if (cpl_valid_i) begin
						hdr_q <= cpl_hdr_i;
						cpl_started_o <= 1'b1;
						tx_req_o <= 1'b1;
						state <= TX_WAIT;
					end
				end
				TX_WAIT: begin
					if (tx_rdy_i) begin
						tx_req_o <= 1'b0;
						tx_st_o <= 1'b1;
						tx_data_o <= hdr_word;
						hcnt <= 3'd1;
						state <= TX_HDR;
					end
				end
				TX_HDR: begin
					tx_data_o <= hdr_word;
					hcnt <= hcnt + 3'd1;
					if (hcnt == 3'd5) begin
						dcnt <= {hdr_q.length, 1'b0};
						state <= TX_DATA;
					end
				end
				TX_DATA: begin
					if (pop) begin
						tx_data_o <= buf_mem[rd_ptr];
						dcnt <= dcnt - 1'b1;
						if (dcnt == 11'd1) begin
							tx_end_o <= 1'b1;
							state <= TX_IDLE;
						end
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/slv_sequencer.sv
`default_nettype none
`include "tlp_consts.svh"

module slv_sequencer (
	input  wire                     pcie_clk,
	input  wire                     sys_rst,
	input  wire tlp_pkg::tlp_hdr_t  hdr_i,
	input  wire                     hdr_valid_i,
	input  wire tlp_pkg::rx_word_t  pay_i,
	output slv_pkg::slv_req_t       slv_o,
	input  wire [`TLP_DATA_W-1:0]   slv_dat_i,
	output tlp_pkg::cpl_hdr_t       cpl_hdr_o,
	output logic                    cpl_valid_o,
	input  wire                     cpl_started_i,
	output logic [`TLP_DATA_W-1:0]  cpl_word_o,
	output logic                    cpl_word_valid_o,
	input  wire                     cpl_credit_i
);
	import tlp_pkg::*;
	import slv_pkg::*;

	seq_state_e state;
	tlp_hdr_t req;
	logic [`TLP_LEN_W:0] cnt;          // Half-words done
	logic [`TLP_LEN_W:0] rd_left;
	logic [2:0] credits;
	logic rd_pend;
	logic issue;
	logic [`SLV_ADR_W-1:0] base;
	logic [`SLV_ADR_W-1:0] adr;
	logic [3:0] be;
	logic [1:0] wr_sel;
	logic [1:0] lead;
	logic [1:0] trail;
	logic [`BCOUNT_W-1:0] bcount;

	// Disabled bytes below the first enabled one
	function automatic logic [1:0] lead_gap(input logic [3:0] mask);
		casez (mask)
			4'b???1: lead_gap = 2'd0;
			4'b??10: lead_gap = 2'd1;
			4'b?100: lead_gap = 2'd2;
			4'b1000: lead_gap = 2'd3;
			default: lead_gap = 2'd0;
		endcase
	endfunction

	// Disabled bytes above the last enabled one
	function automatic logic [1:0] trail_gap(input logic [3:0] mask);
		casez (mask)
			4'b1???: trail_gap = 2'd0;
			4'b01??: trail_gap = 2'd1;
			4'b001?: trail_gap = 2'd2;
			default: trail_gap = 2'd3;
		endcase
	endfunction

	assign base = {req.addr[19:2], 1'b0};
	assign adr = base + {{(`SLV_ADR_W-`TLP_LEN_W-1){1'b0}}, cnt};
	assign issue = (state == READ_DATA) && (rd_left != '0) && (credits != 3'd0);

	assign lead = lead_gap(req.first_be);
	assign trail = (req.length == 10'd1) ? trail_gap(req.first_be) : trail_gap(req.last_be);
	assign bcount = {req.length, 2'b00} - {{(`BCOUNT_W-2){1'b0}}, lead}
		- {{(`BCOUNT_W-2){1'b0}}, trail};

	always_comb begin
		if (cnt[`TLP_LEN_W:1] == '0)
			be = req.first_be;
		else if (cnt[`TLP_LEN_W:1] == req.length - 10'd1)
			be = req.last_be;
		else
			be = 4'hf;
		wr_sel = cnt[0] ? {be[2], be[3]} : {be[0], be[1]};
	end

	// Read data lands one cycle after the strobe
	assign cpl_word_o = slv_dat_i;
	assign cpl_word_valid_o = rd_pend;

	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			state <= IDLE;
			slv_o.ce <= 1'b0;
			slv_o.we <= 1'b0;
			cpl_valid_o <= 1'b0;
			credits <= 3'(`CPL_BUF_DEPTH);
			rd_pend <= 1'b0;
			cnt <= '0;
			rd_left <= '0;
		end else begin
			slv_o.ce <= 1'b0;
			slv_o.we <= 1'b0;
			rd_pend <= slv_o.ce & ~slv_o.we;
			credits <= credits - {2'b00, issue} + {2'b00, cpl_credit_i};
			if (cpl_started_i)
				cpl_valid_o <= 1'b0;
			case (state)
				IDLE: begin
					if (hdr_valid_i && hdr_i.kind == MEM && hdr_i.bar_hit != '0) begin
						req <= hdr_i;
						cnt <= '0;
						if (hdr_i.fmt[1])
							state <= WRITE;
						else
							state <= READ_HDR;
					end
				end
				WRITE: begin
					if (pay_i.valid) begin
						slv_o.bar <= req.bar_hit;
						slv_o.ce <= 1'b1;
						slv_o.we <= 1'b1;
						slv_o.adr <= adr;
						slv_o.dat <= pay_i.data;
						slv_o.sel <= wr_sel;
						cnt <= cnt + 1'b1;
						if (pay_i.last)
							state <= IDLE;
					end
				end
				READ_HDR: begin
					cpl_hdr_o.length <= req.length;
					cpl_hdr_o.bcount <= bcount;
					cpl_hdr_o.req_id <= req.req_id;
					cpl_hdr_o.tag <= req.tag;
					cpl_hdr_o.low_addr <= {req.addr[6:2], lead};
					cpl_valid_o <= 1'b1;
					rd_left <= {req.length, 1'b0};
					state <= READ_DATA;
				end
				READ_DATA: begin
					if (issue) begin
						slv_o.bar <= req.bar_hit;
						slv_o.ce <= 1'b1;
						slv_o.adr <= adr;
						slv_o.sel <= 2'b11;
						cnt <= cnt + 1'b1;
						rd_left <= rd_left - 1'b1;
					end
					if (rd_left == '0 && !cpl_valid_o)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/rx_credit_release.sv
`default_nettype none
`include "tlp_consts.svh"

module rx_credit_release (
	input  wire                    pcie_clk,
	input  wire                    sys_rst,
	input  wire tlp_pkg::tlp_hdr_t hdr_i,
	input  wire                    tlp_end_i,
	output logic [7:0]             pd_num_o,
	output logic                   ph_cr_o,
	output logic                   pd_cr_o,
	output logic                   nph_cr_o,
	output logic                   npd_cr_o
);
	import tlp_pkg::*;

	logic [7:0] pd_cnt;

	// Doublewords to data credits, rounded up
	assign pd_cnt = hdr_i.length[`TLP_LEN_W-1:2] + {7'd0, |hdr_i.length[1:0]};

	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			pd_num_o <= 8'h0;
			ph_cr_o <= 1'b0;
			pd_cr_o <= 1'b0;
			nph_cr_o <= 1'b0;
			npd_cr_o <= 1'b0;
		end else begin
			pd_num_o <= 8'h0;
			ph_cr_o <= 1'b0;
			pd_cr_o <= 1'b0;
			nph_cr_o <= 1'b0;
			npd_cr_o <= 1'b0;
			if (tlp_end_i) begin
				case (hdr_i.kind)
					MEM, MEM_LK: begin
						if (hdr_i.bar_hit != '0) begin
							if (hdr_i.fmt[1]) begin
								ph_cr_o <= 1'b1;
								pd_cr_o <= 1'b1;
								pd_num_o <= pd_cnt;
							end else
								nph_cr_o <= 1'b1;
						end
					end
					IO, CFG0, CFG1: begin
						nph_cr_o <= 1'b1;
						npd_cr_o <= hdr_i.fmt[1];
					end
					MSG: begin
						ph_cr_o <= 1'b1;
						if (hdr_i.fmt[1]) begin
							pd_cr_o <= 1'b1;
							pd_num_o <= pd_cnt;
						end
					end
					default: ;   // Completions return nothing
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/tlp_rx_parser.sv
`default_nettype none
`include "tlp_consts.svh"

module tlp_rx_parser (
	input  wire                    pcie_clk,
	input  wire                    sys_rst,
	input  wire [`BAR_W-1:0]       rx_bar_hit_i,
	input  wire                    rx_st_i,
	input  wire                    rx_end_i,
	input  wire [`TLP_DATA_W-1:0]  rx_data_i,
	output tlp_pkg::tlp_hdr_t      hdr_o,
	output logic                   hdr_valid_o,
	output logic                   tlp_end_o,
	output tlp_pkg::rx_word_t      pay_o
);
	import tlp_pkg::*;

	rx_state_e state;

	// Only an end inside a packet counts
	assign tlp_end_o = rx_end_i && (state != RX_H0);

	//----------------------------------------------------------------------
	// Header walk
	//----------------------------------------------------------------------
	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			state <= RX_H0;
			hdr_valid_o <= 1'b0;
			pay_o.valid <= 1'b0;
			pay_o.last <= 1'b0;
		end else begin
			hdr_valid_o <= 1'b0;
			pay_o.valid <= 1'b0;
			pay_o.last <= 1'b0;
			pay_o.data <= rx_data_i;
			case (state)
				RX_H0: begin
					if (rx_st_i) begin
						hdr_o.fmt <= rx_data_i[14:13];
						hdr_o.tc <= rx_data_i[6:4];
						hdr_o.bar_hit <= rx_bar_hit_i;
						if (rx_data_i[12])
							hdr_o.kind <= MSG;
						else if (!rx_data_i[11]) begin
							case (rx_data_i[10:8])
								3'b000: hdr_o.kind <= MEM;
								3'b001: hdr_o.kind <= MEM_LK;
								3'b010: hdr_o.kind <= IO;
								3'b100: hdr_o.kind <= CFG0;
								default: hdr_o.kind <= CFG1;
							endcase
						end else
							hdr_o.kind <= rx_data_i[8] ? CPL_LK : CPL;
						state <= RX_H1;
					end
				end
				RX_H1: begin
					hdr_o.attr <= rx_data_i[13:12];
					hdr_o.length <= rx_data_i[`TLP_LEN_W-1:0];
					state <= RX_H2;
				end
				RX_H2: begin
					hdr_o.req_id <= rx_data_i;
					state <= RX_H3;
				end
				RX_H3: begin
					hdr_o.tag <= rx_data_i[15:8];
					hdr_o.last_be <= rx_data_i[7:4];
					hdr_o.first_be <= rx_data_i[3:0];
					if (hdr_o.fmt[0])
						state <= RX_H4;
					else begin
						hdr_o.addr[63:32] <= '0;   // 3DW, no upper words
						state <= RX_H6;
					end
				end
				RX_H4: begin
					hdr_o.addr[63:48] <= rx_data_i;
					state <= RX_H5;
				end
				RX_H5: begin
					hdr_o.addr[47:32] <= rx_data_i;
					state <= RX_H6;
				end
				RX_H6: begin
					hdr_o.addr[31:16] <= rx_data_i;
					state <= RX_H7;
				end
				RX_H7: begin
					hdr_o.addr[15:2] <= rx_data_i[15:2];
					hdr_valid_o <= 1'b1;
					state <= RX_PAY;
				end
				RX_PAY: begin
					pay_o.valid <= 1'b1;
					pay_o.last <= rx_end_i;
				end
				default: state <= RX_H0;
			endcase
			if (rx_end_i)
				state <= RX_H0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/slv_pkg.sv
`default_nettype none
`include "tlp_consts.svh"

package slv_pkg;

	typedef struct packed {
		logic [`BAR_W-1:0]      bar;
		logic                   ce;      // One-cycle strobe
		logic                   we;
		logic [`SLV_ADR_W:1]    adr;     // Half-word address
		logic [`TLP_DATA_W-1:0] dat;
		logic [1:0]             sel;     // Bit 1 is the lower byte
	} slv_req_t;

	typedef enum logic [1:0] {
		IDLE, WRITE, READ_HDR, READ_DATA
	} seq_state_e;

endpackage

`default_nettype wire

// File: verilog/tlp_pkg.sv
`default_nettype none
`include "tlp_consts.svh"

package tlp_pkg;

	typedef enum logic [2:0] {
		MEM,
		MEM_LK,
		IO,
		CFG0,
		CFG1,
		MSG,
		CPL,
		CPL_LK
	} tlp_kind_e;

	typedef struct packed {
		logic [7:0] bus;
		logic [4:0] dev;
		logic [2:0] func;
	} cfg_id_t;

	typedef struct packed {
		logic [1:0]            fmt;      // Bit 1 set when data follows
		tlp_kind_e             kind;
		logic [2:0]            tc;
		logic [1:0]            attr;
		logic [`TLP_LEN_W-1:0] length;   // Doublewords
		logic [15:0]           req_id;
		logic [7:0]            tag;
		logic [3:0]            last_be;
		logic [3:0]            first_be;
		logic [63:2]           addr;
		logic [`BAR_W-1:0]     bar_hit;
	} tlp_hdr_t;

	typedef struct packed {
		logic                   valid;
		logic                   last;
		logic [`TLP_DATA_W-1:0] data;
	} rx_word_t;

	typedef struct packed {
		logic [`TLP_LEN_W-1:0] length;
		logic [`BCOUNT_W-1:0]  bcount;
		logic [15:0]           req_id;
		logic [7:0]            tag;
		logic [6:0]            low_addr;
	} cpl_hdr_t;

	typedef enum logic [3:0] {
		RX_H0, RX_H1, RX_H2, RX_H3, RX_H4, RX_H5, RX_H6, RX_H7, RX_PAY
	} rx_state_e;

	typedef enum logic [1:0] {
		TX_IDLE, TX_WAIT, TX_HDR, TX_DATA
	} tx_state_e;

endpackage

`default_nettype wire

// File: verilog/tlp_consts.svh
`ifndef TLP_CONSTS_SVH
`define TLP_CONSTS_SVH

// Link stream
`define TLP_DATA_W 16
`define TLP_LEN_W 10

// Management inputs
`define BAR_W 7

// Local slave bus, half-word addressed
`define SLV_ADR_W 19

// Completion fields
`define BCOUNT_W 12

// Completion word buffer, also the initial credit count
`define CPL_BUF_DEPTH 4

//----------------------------------------------------------------------
// Header codes
//----------------------------------------------------------------------
`define FMT_3DW_DATA 2'b10
`define TYPE_CPL 5'b01010

`endif
